/* vector_execute_stage.f */
source/vex_pkg.sv
source/vector_lane.sv
source/ls_addr_gen.sv
source/ex_mem_latch.sv
source/vector_execute_stage.sv
testbench/vector_execute_stage_asserts.sv
testbench/vector_execute_stage_tb.sv

/* testbench/vector_execute_stage_tb.sv */
// random ALU, reduction, load/store and scalar beats with a model of the to_mem bundle
// each beat is followed by one idle cycle, so addresses chain only across load/store beats
`timescale 1ns/100ps
`default_nettype none

module vector_execute_stage_tb;

  import vex_pkg::*;

  localparam int OFFSET_W = 5;
  // about four times the length of the stimulus
  localparam int TIMEOUT_CYCLES = 1000;

  logic                CLK = 1'b0;
  logic                nRST;
  ex_issue_t           issue;
  logic [OFFSET_W-1:0] woffset0;
  logic [OFFSET_W-1:0] woffset1;
  logic                stall;
  logic                flush;
  mem_out_t            to_mem;
  word_t               rng = 32'h6d20_b152;
  int                  cycle_count = 0;

  vector_execute_stage #(
    .OFFSET_W (OFFSET_W)
  ) dut_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .issue    (issue),
    .woffset0 (woffset0),
    .woffset1 (woffset1),
    .stall    (stall),
    .flush    (flush),
    .to_mem   (to_mem)
  );

  always #2 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (dut_i.asserts_i.error_count != 0) begin
      $display("a concurrent assertion failed at %0t", $time);
      $display("test failed");
      $fatal(1, "concurrent assertion failure");
    end else if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("the run timed out after %0d cycles", cycle_count);
      $display("test failed");
      $fatal(1, "timeout");
    end
  end

  function automatic word_t xorshift_next();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic word_t select_operand(opsrc_e src, word_t vword, word_t imm, word_t xreg);
    case (src)
      SRC_V:   return vword;
      SRC_I:   return imm;
      SRC_X:   return xreg;
      default: return '0;
    endcase
  endfunction

  // signed compares on the low sew bits, the result keeps the whole word
  function automatic word_t model_alu(aluop_e op, sew_e sew, word_t a, word_t b);
    int sh;
    int sa;
    int sb;
    sh = (sew == SEW8) ? 24 : (sew == SEW16) ? 16 : 0;
    sa = $signed(a << sh) >>> sh;
    sb = $signed(b << sh) >>> sh;
    case (op)
      VALU_ADD:  return a + b;
      VALU_AND:  return a & b;
      VALU_OR:   return a | b;
      VALU_XOR:  return a ^ b;
      VALU_MIN:  return (sa < sb) ? a : b;
      VALU_MAX:  return (sa < sb) ? b : a;
      VALU_MINU: return (a < b) ? a : b;
      default:   return (a < b) ? b : a;
    endcase
  endfunction

  function automatic ex_issue_t random_alu_beat();
    ex_issue_t b;
    b         = '0;
    b.valid   = 1'b1;
    b.fu      = FU_ALU;
    b.aluop   = aluop_e'(3'(xorshift_next()));
    b.sew     = sew_e'(2'(xorshift_next() % 3));
    b.rs1_src = opsrc_e'(2'(xorshift_next()));
    b.rs2_src = opsrc_e'(2'(xorshift_next()));
    b.vs1[0]  = xorshift_next();
    b.vs1[1]  = xorshift_next();
    b.vs2[0]  = xorshift_next();
    b.vs2[1]  = xorshift_next();
    b.vs3[0]  = xorshift_next();
    b.vs3[1]  = xorshift_next();
    b.imm     = xorshift_next();
    b.xs1     = xorshift_next();
    b.xs2     = xorshift_next();
    b.vd      = 5'(xorshift_next());
    b.rd_sel  = 5'(xorshift_next());
    b.wen     = 2'(xorshift_next());
    return b;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("test failed");
      $fatal(1, "field check failed");
    end
  endtask

  task automatic run_beat(input ex_issue_t b, input logic [OFFSET_W-1:0] w0);
    word_t               lane0;
    word_t               lane1;
    word_t               elem;
    word_t               step;
    word_t               base;
    word_t               k;
    word_t               exp_rd;
    logic [OFFSET_W-1:0] w1;
    logic                taken;
    lane0 = model_alu(b.aluop, b.sew, select_operand(b.rs1_src, b.vs1[0], b.imm, b.xs1),
                      select_operand(b.rs2_src, b.vs2[0], b.imm, b.xs2));
    lane1 = model_alu(b.aluop, b.sew, select_operand(b.rs1_src, b.vs1[1], b.imm, b.xs1),
                      select_operand(b.rs2_src, b.vs2[1], b.imm, b.xs2));
    elem = (b.sew == SEW8) ? 32'd1 : (b.sew == SEW16) ? 32'd2 : 32'd4;
    case (b.stride)
      STRIDE_CONST:   step = b.xs2;
      STRIDE_SEGMENT: step = (word_t'(b.nf) + 32'd1) * elem;
      default:        step = elem;
    endcase
    base = b.xs1 + word_t'(b.nf_count) * elem;
    k = word_t'(w0 >> 1);
    w1 = w0 + 1'b1;
    exp_rd = (b.fu == FU_CONFIG) ? b.vl : (b.rd_from_vs2 ? b.vs2[0] : '0);
    @(posedge CLK);
    issue    <= b;
    woffset0 <= w0;
    woffset1 <= w1;
    stall    <= (xorshift_next() % 4) == 0;
    // wait for the edge that takes the beat
    do begin
      @(posedge CLK);
      taken = !stall;
      if (!taken) begin
        stall <= (xorshift_next() % 2) == 0;
      end
    end while (!taken);
    issue <= '0;
    stall <= 1'b0;
    @(negedge CLK);
    check_word("valid", word_t'(to_mem.valid), 32'd1);
    check_word("load_ena", word_t'(to_mem.load_ena), word_t'(b.fu == FU_LOAD));
    check_word("store_ena", word_t'(to_mem.store_ena), word_t'(b.fu == FU_STORE));
    check_word("wen", word_t'(to_mem.wen), word_t'(b.wen));
    check_word("vd", word_t'(to_mem.vd), word_t'(b.vd));
    check_word("rd_sel", word_t'(to_mem.rd_sel), word_t'(b.rd_sel));
    check_word("woffset0", to_mem.woffset0, word_t'(w0));
    check_word("woffset1", to_mem.woffset1, word_t'(w1));
    check_word("rd_wen", word_t'(to_mem.rd_wen), word_t'(b.rd_wen | (b.fu == FU_CONFIG)));
    check_word("rd_data", to_mem.rd_data, exp_rd);
    check_word("result0", to_mem.result0,
               b.reduction ? model_alu(b.aluop, b.sew, lane0, lane1) : lane0);
    check_word("result1", to_mem.result1, lane1);
    check_word("storedata0", to_mem.storedata0, b.vs3[0]);
    check_word("storedata1", to_mem.storedata1, b.vs3[1]);
    if (b.fu == FU_LOAD || b.fu == FU_STORE) begin
      check_word("addr0", to_mem.addr0, base + (k * 32'd2) * step);
      check_word("addr1", to_mem.addr1, base + (k * 32'd2 + 32'd1) * step);
    end
  endtask

  // a valid beat that meets a flush, sometimes with stall too
  task automatic flush_beat(input ex_issue_t b);
    @(posedge CLK);
    issue <= b;
    flush <= 1'b1;
    stall <= (xorshift_next() % 2) == 0;
    @(posedge CLK);
    issue <= '0;
    flush <= 1'b0;
    stall <= 1'b0;
  endtask

  task automatic run_ls_sequence(input fu_e fu, input stride_e mode);
    ex_issue_t b;
    int        k;
    b          = random_alu_beat();
    b.fu       = fu;
    b.stride   = mode;
    b.nf       = 3'(xorshift_next());
    b.nf_count = 3'(xorshift_next() % (b.nf + 1));
    for (k = 0; k < 4; k++) begin
      b.vs3[0] = xorshift_next();
      b.vs3[1] = xorshift_next();
      run_beat(b, OFFSET_W'(2 * k));
    end
  endtask

  initial begin
    ex_issue_t b;
    int        i;
    nRST     = 1'b0;
    issue    = '0;
    woffset0 = '0;
    woffset1 = '0;
    stall    = 1'b0;
    flush    = 1'b0;
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;
    for (i = 0; i < 64; i++) begin
      run_beat(random_alu_beat(), '0);
      if ((xorshift_next() % 8) == 0) begin
        flush_beat(random_alu_beat());
      end
    end
    for (i = 0; i < 16; i++) begin
      b = random_alu_beat();
      b.reduction = 1'b1;
      run_beat(b, '0);
    end
    run_ls_sequence(FU_LOAD, STRIDE_UNIT);
    run_ls_sequence(FU_STORE, STRIDE_UNIT);
    run_ls_sequence(FU_LOAD, STRIDE_CONST);
    run_ls_sequence(FU_STORE, STRIDE_CONST);
    run_ls_sequence(FU_LOAD, STRIDE_SEGMENT);
    run_ls_sequence(FU_STORE, STRIDE_SEGMENT);
    // scalar destination, vl and then element 0 of vs2
    b = random_alu_beat();
    b.fu = FU_CONFIG;
    b.vl = xorshift_next();
    run_beat(b, '0);
    b = random_alu_beat();
    b.rd_from_vs2 = 1'b1;
    b.rd_wen = 1'b1;
    run_beat(b, '0);
    repeat (2) @(posedge CLK);
    if (dut_i.asserts_i.error_count != 0) begin
      $display("a concurrent assertion failed during the run");
      $display("test failed");
      $fatal(1, "concurrent assertion failure");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* testbench/vector_execute_stage_asserts.sv */
// reset, stall and flush checks on to_mem, bound into vector_execute_stage
// error_count holds the number of failed checks
`timescale 1ns/100ps
`default_nettype none

module vector_execute_stage_asserts (
  input logic               CLK,
  input logic               nRST,
  input vex_pkg::ex_issue_t issue,
  input logic               stall,
  input logic               flush,
  input vex_pkg::mem_out_t  to_mem
);

  int         error_count = 0;
  logic       seen_beat;
  logic [5:0] ctrl;

  assign ctrl = {to_mem.valid, to_mem.load_ena, to_mem.store_ena, to_mem.wen, to_mem.rd_wen};

  // set once the first beat is taken
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      seen_beat <= 1'b0;
    end else if (issue.valid && !stall && !flush) begin
      seen_beat <= 1'b1;
    end
  end

  idle_after_reset: assert property (@(posedge CLK) disable iff (!nRST)
    !seen_beat |-> ctrl == '0)
    else begin
      $error("valid or an enable is set before the first beat");
      error_count++;
    end

  hold_on_stall: assert property (@(posedge CLK) disable iff (!nRST)
    (stall && !flush) |=> $stable(to_mem))
    else begin
      $error("to_mem changed during a stall");
      error_count++;
    end

  clear_on_flush: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> ctrl == '0)
    else begin
      $error("valid or an enable is set after a flush");
      error_count++;
    end

  valid_after_beat: assert property (@(posedge CLK) disable iff (!nRST)
    (issue.valid && !stall && !flush) |=> to_mem.valid)
    else begin
      $error("a taken beat did not reach to_mem");
      error_count++;
    end

endmodule

bind vector_execute_stage vector_execute_stage_asserts asserts_i (
  .CLK    (CLK),
  .nRST   (nRST),
  .issue  (issue),
  .stall  (stall),
  .flush  (flush),
  .to_mem (to_mem)
);

`default_nettype wire

/* source/vector_execute_stage.sv */
// two lane vector execute stage, one cycle from issue to to_mem
// during a stall decode must hold issue steady
`timescale 1ns/100ps
`default_nettype none

module vector_execute_stage #(
  parameter int OFFSET_W = 5
) (
  input  logic                CLK,
  input  logic                nRST,
  input  vex_pkg::ex_issue_t  issue,
  input  logic [OFFSET_W-1:0] woffset0,
  input  logic [OFFSET_W-1:0] woffset1,
  input  logic                stall,
  input  logic                flush,
  output vex_pkg::mem_out_t   to_mem
);

  import vex_pkg::*;

  word_t lane0_res;
  word_t lane1_res;
  word_t addr0;
  word_t addr1;

  // both lanes share the issue bundle
  vector_lane lane0_i (
    .issue    (issue),
    .lane_sel (1'b0),
    .result   (lane0_res)
  );

  vector_lane lane1_i (
    .issue    (issue),
    .lane_sel (1'b1),
    .result   (lane1_res)
  );

  ls_addr_gen #(
    .OFFSET_W (OFFSET_W)
  ) addr_gen_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .issue    (issue),
    .woffset0 (woffset0),
    .stall    (stall),
    .flush    (flush),
    .addr0    (addr0),
    .addr1    (addr1)
  );

  ex_mem_latch #(
    .OFFSET_W (OFFSET_W)
  ) latch_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .issue     (issue),
    .woffset0  (woffset0),
    .woffset1  (woffset1),
    .lane0_res (lane0_res),
    .lane1_res (lane1_res),
    .addr0     (addr0),
    .addr1     (addr1),
    .stall     (stall),
    .flush     (flush),
    .to_mem    (to_mem)
  );

endmodule

`default_nettype wire

/* source/ex_mem_latch.sv */
// execute to memory register, one cycle
// flush wins over stall and clears valid and all enables
`timescale 1ns/100ps
`default_nettype none

module ex_mem_latch #(
  parameter int OFFSET_W = 5
) (
  input  logic                CLK,
  input  logic                nRST,
  input  vex_pkg::ex_issue_t  issue,
  input  logic [OFFSET_W-1:0] woffset0,
  input  logic [OFFSET_W-1:0] woffset1,
  input  vex_pkg::word_t      lane0_res,
  input  vex_pkg::word_t      lane1_res,
  input  vex_pkg::word_t      addr0,
  input  vex_pkg::word_t      addr1,
  input  logic                stall,
  input  logic                flush,
  output vex_pkg::mem_out_t   to_mem
);

  import vex_pkg::*;

  mem_out_t nxt;
  word_t    red_res;
  logic     is_config;

  // lane 0 and lane 1 folded with the same op
  assign red_res   = alu_apply(issue.aluop, issue.sew, lane0_res, lane1_res);
  assign is_config = issue.fu == FU_CONFIG;

  always_comb begin
    nxt            = '0;
    nxt.valid      = issue.valid;
    // enables only on a valid beat
    nxt.load_ena   = issue.valid & (issue.fu == FU_LOAD);
    nxt.store_ena  = issue.valid & (issue.fu == FU_STORE);
    nxt.wen        = issue.valid ? issue.wen : 2'b00;
    nxt.rd_wen     = issue.valid & (issue.rd_wen | is_config);
    nxt.result0    = issue.reduction ? red_res : lane0_res;
    nxt.result1    = lane1_res;
    nxt.addr0      = addr0;
    nxt.addr1      = addr1;
    nxt.storedata0 = issue.vs3[0];
    nxt.storedata1 = issue.vs3[1];
    nxt.vd         = issue.vd;
    nxt.rd_sel     = issue.rd_sel;
    nxt.woffset0   = word_t'(woffset0);
    nxt.woffset1   = word_t'(woffset1);
    // scalar result, vl for config or element 0 of vs2 for a move
    if (is_config) begin
      nxt.rd_data = issue.vl;
    end else if (issue.rd_from_vs2) begin
      nxt.rd_data = issue.vs2[0];
    end else begin
      nxt.rd_data = '0;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      to_mem <= '0;
    end else if (flush) begin
      // payload kept, only control dropped
      to_mem.valid     <= 1'b0;
      to_mem.load_ena  <= 1'b0;
      to_mem.store_ena <= 1'b0;
      to_mem.wen       <= 2'b00;
      to_mem.rd_wen    <= 1'b0;
    end else if (!stall) begin
      to_mem <= nxt;
    end
  end

endmodule

`default_nettype wire

/* source/ls_addr_gen.sv */
// load/store address pair for the two lanes, unit, constant and segment stride
// woffset0 of zero starts a new sequence from the field base
`timescale 1ns/100ps
`default_nettype none

module ls_addr_gen #(
  parameter int OFFSET_W = 5
) (
  input  logic               CLK,
  input  logic               nRST,
  input  vex_pkg::ex_issue_t issue,
  input  logic [OFFSET_W-1:0] woffset0,
  input  logic               stall,
  input  logic               flush,
  output vex_pkg::word_t     addr0,
  output vex_pkg::word_t     addr1
);

  import vex_pkg::*;

  logic [1:0] size_sh;
  word_t      elem_bytes;
  word_t      stride;
  word_t      field_base;
  word_t      addr_q;
  logic       ls_beat;

  // log2 of element size in bytes
  always_comb begin
    case (issue.sew)
      SEW8:    size_sh = 2'd0;
      SEW16:   size_sh = 2'd1;
      default: size_sh = 2'd2;
    endcase
  end

  assign elem_bytes = word_t'(1) << size_sh;

  always_comb begin
    case (issue.stride)
      STRIDE_CONST:   stride = issue.xs2;
      // nf+1 fields per segment
      STRIDE_SEGMENT: stride = (word_t'(issue.nf) + word_t'(1)) << size_sh;
      default:        stride = elem_bytes;
    endcase
  end

  assign field_base = issue.xs1 + (word_t'(issue.nf_count) << size_sh);

  // lane 1 chains off lane 0
  assign addr0 = (woffset0 == '0) ? field_base : addr_q + stride;
  assign addr1 = addr0 + stride;

  assign ls_beat = issue.valid & ~stall & ((issue.fu == FU_LOAD) | (issue.fu == FU_STORE));

  // running address, last address of the previous beat
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      addr_q <= '0;
    end else if (flush) begin
      addr_q <= '0;
    end else if (ls_beat) begin
      addr_q <= addr1;
    end
  end

endmodule

`default_nettype wire

/* source/vector_lane.sv */
// one combinational ALU lane, no state
// lane_sel picks half 0 or 1 of the vs pairs
`timescale 1ns/100ps
`default_nettype none

module vector_lane (
  input  vex_pkg::ex_issue_t issue,
  input  logic               lane_sel,
  output vex_pkg::word_t     result
);

  import vex_pkg::*;

  lane_ops_t ops;

  // operand 1 from rs1 source
  always_comb begin
    case (issue.rs1_src)
      SRC_V:   ops.opnd1 = issue.vs1[lane_sel];
      SRC_I:   ops.opnd1 = issue.imm;
      SRC_X:   ops.opnd1 = issue.xs1;
      default: ops.opnd1 = '0;
    endcase
  end

  // operand 2 from rs2 source
  always_comb begin
    case (issue.rs2_src)
      SRC_V:   ops.opnd2 = issue.vs2[lane_sel];
      SRC_I:   ops.opnd2 = issue.imm;
      SRC_X:   ops.opnd2 = issue.xs2;
      default: ops.opnd2 = '0;
    endcase
  end

  assign ops.aluop = issue.aluop;
  assign ops.sew   = issue.sew;

  assign result = alu_apply(ops.aluop, ops.sew, ops.opnd1, ops.opnd2);

endmodule

`default_nettype wire

/* source/vex_pkg.sv */
// types and the ALU function shared by the vector execute stage
// min/max signed compares use the element width, unsigned compares use all 32 bits
`default_nettype none

package vex_pkg;

  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;

  typedef enum logic [1:0] {
    SEW8,
    SEW16,
    SEW32
  } sew_e;

  typedef enum logic [1:0] {
    FU_ALU,
    FU_LOAD,
    FU_STORE,
    FU_CONFIG
  } fu_e;

  typedef enum logic [2:0] {
    VALU_ADD,
    VALU_AND,
    VALU_OR,
    VALU_XOR,
    VALU_MIN,
    VALU_MINU,
    VALU_MAX,
    VALU_MAXU
  } aluop_e;

  typedef enum logic [1:0] {
    SRC_V,
    SRC_I,
    SRC_X,
    SRC_NONE
  } opsrc_e;

  typedef enum logic [1:0] {
    STRIDE_UNIT,
    STRIDE_CONST,
    STRIDE_SEGMENT
  } stride_e;

  // decode to execute bundle, vs pairs are indexed by lane
  typedef struct packed {
    logic        valid;
    fu_e         fu;
    aluop_e      aluop;
    sew_e        sew;
    opsrc_e      rs1_src;
    opsrc_e      rs2_src;
    logic        reduction;
    word_t [1:0] vs1;
    word_t [1:0] vs2;
    word_t [1:0] vs3;
    word_t       imm;
    word_t       xs1;
    word_t       xs2;
    stride_e     stride;
    logic [2:0]  nf;
    logic [2:0]  nf_count;
    word_t       vl;
    logic [4:0]  rd_sel;
    logic        rd_wen;
    logic        rd_from_vs2;
    logic [4:0]  vd;
    logic [1:0]  wen;
  } ex_issue_t;

  typedef struct packed {
    word_t  opnd1;
    word_t  opnd2;
    aluop_e aluop;
    sew_e   sew;
  } lane_ops_t;

  // woffset fields are zero extended element offsets for the writeback
  typedef struct packed {
    logic       valid;
    logic       load_ena;
    logic       store_ena;
    word_t      result0;
    word_t      result1;
    word_t      addr0;
    word_t      addr1;
    word_t      storedata0;
    word_t      storedata1;
    logic [1:0] wen;
    logic [4:0] vd;
    logic       rd_wen;
    logic [4:0] rd_sel;
    word_t      rd_data;
    word_t      woffset0;
    word_t      woffset1;
  } mem_out_t;

  function automatic word_t alu_apply(aluop_e op, sew_e sew, word_t a, word_t b);
    logic  lt_s;
    logic  lt_u;
    word_t res;
    lt_u = a < b;
    case (sew)
      SEW8:    lt_s = $signed(a[7:0]) < $signed(b[7:0]);
      SEW16:   lt_s = $signed(a[15:0]) < $signed(b[15:0]);
      default: lt_s = $signed(a) < $signed(b);
    endcase
    case (op)
      VALU_ADD:  res = a + b;
      VALU_AND:  res = a & b;
      VALU_OR:   res = a | b;
      VALU_XOR:  res = a ^ b;
      VALU_MIN:  res = lt_s ? a : b;
      VALU_MINU: res = lt_u ? a : b;
      VALU_MAX:  res = lt_s ? b : a;
      default:   res = lt_u ? b : a;
    endcase
    return res;
  endfunction

endpackage

`default_nettype wire
